// ==== src.f ====
+incdir+logic
logic/mxu_arith_pkg.sv
logic/mxu_ctrl_pkg.sv
logic/mxu_mac.sv
logic/mxu_core.sv
logic/skew_line.sv
logic/mxu_timer.sv
logic/mxu_seq.sv
logic/mxu_top.sv
tests/tb_clkgen.sv
tests/mxu_tb.sv

// ==== Makefile ====
TOOL        = verilator
TOP         = mxu_tb
RTL_TOP     = mxu_top
FILELIST    = src.f
OBJ_DIR     = obj_dir
BIN         = mxu_sim
LOG         = sim.log
PASS_MSG    = Simulation completed successfully
LINT_FLAGS  = --lint-only --timing -Wall -Wno-fatal
BUILD_FLAGS = --binary --timing -Wno-fatal -Mdir $(OBJ_DIR) -o $(BIN)

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(BUILD_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/$(BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tests/mxu_tb.sv ====
`timescale 1ns/100ps
`include "mxu_macros.svh"

module mxu_tb;
   import mxu_arith_pkg::*;
   import mxu_ctrl_pkg::*;

   typedef acc_t     [`MXU_ROWS-1:0] yvec_t;
   typedef operand_t [`MXU_COLS-1:0] ovec_t;

   logic     clk;
   logic     rst_n;
   logic     start;
   prec_e    data_type;
   logic     w_load;
   ovec_t    w_row;
   logic     in_valid;
   logic     in_last;
   ovec_t    x_vec;
   yvec_t    y_vec;
   logic     out_valid;
   logic     busy;
   logic     loading;
   logic     done;

   int       cycle = 0;
   int       cycle_limit = 16 + 8 + 20;  // reset, idle check, margin
   int       value_errs = 0;
   int       other_errs = 0;
   int       sent = 0;
   int       received = 0;
   int       last_cyc;
   int       want_cyc;
   yvec_t    want_y;

   operand_t w_model [`MXU_ROWS][`MXU_COLS];  // weights as placed in the grid
   prec_e    job_prec;
   yvec_t    exp_y [$];
   int       exp_cyc [$];

   tb_clkgen #(.PERIOD(20.0), .RESET_CYCLES(16)) u_clkgen (.clk(clk), .rst_n(rst_n));

   mxu_top UUT (
      .clk       (clk),
      .rst_n     (rst_n),
      .start     (start),
      .data_type (data_type),
      .w_load    (w_load),
      .w_row     (w_row),
      .in_valid  (in_valid),
      .in_last   (in_last),
      .x_vec     (x_vec),
      .y_vec     (y_vec),
      .out_valid (out_valid),
      .busy      (busy),
      .loading   (loading),
      .done      (done)
   );

   ////////////////////////////////////////
   // reference model
   ////////////////////////////////////////
   function automatic int operand_value(operand_t v, prec_e p);
      if (p == PREC_INT8) return int'(signed'(v));
      return int'(v);
   endfunction

   function automatic yvec_t expected_y(ovec_t x);
      yvec_t y;
      int    sum;
      for (int r = 0; r < `MXU_ROWS; r++) begin
         sum = 0;
         for (int c = 0; c < `MXU_COLS; c++) begin
            sum += operand_value(w_model[r][c], job_prec) * operand_value(x[c], job_prec);
         end
         y[r] = acc_t'(sum);
      end
      return y;
   endfunction

   function automatic operand_t pick_operand(bit extreme);
      if (!extreme) return operand_t'($urandom);
      case ($urandom_range(4, 0))
         0:       return 8'h00;
         1:       return 8'h01;
         2:       return 8'h7f;
         3:       return 8'h80;
         default: return 8'hff;
      endcase
   endfunction

   function automatic ovec_t random_vec(bit extreme);
      ovec_t v;
      for (int c = 0; c < `MXU_COLS; c++) begin
         v[c] = pick_operand(extreme);
      end
      return v;
   endfunction

   task automatic check_acc(string name, acc_t got, acc_t exp);
      if (got !== exp) begin
         value_errs++;
         $display("Error at %t: %s is %0d, expected %0d", $realtime, name, got, exp);
      end
   endtask

   task automatic check_flag(string name, logic got, logic exp);
      if (got !== exp) begin
         value_errs++;
         $display("Error at %t: %s is %b, expected %b", $realtime, name, got, exp);
      end
   endtask

   ////////////////////////////////////////
   // cycle count, watchdog, result monitor
   ////////////////////////////////////////
   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (cycle > cycle_limit) begin
         $display("Timeout: the job did not finish within %0d cycles", cycle_limit);
         $display("Simulation failed");
         $finish;
      end
   end

   always @(negedge clk) begin
      if (rst_n && out_valid) begin
         received++;
         if (exp_y.size() == 0) begin
            other_errs++;
            $display("Error at %t: out_valid high with no vector in flight", $realtime);
         end else begin
            want_y   = exp_y.pop_front();
            want_cyc = exp_cyc.pop_front();
            if (cycle != want_cyc) begin
               other_errs++;
               $display("Error at %t: result came in cycle %0d, expected in cycle %0d",
                        $realtime, cycle, want_cyc);
            end
            for (int r = 0; r < `MXU_ROWS; r++) begin
               check_acc($sformatf("y_vec[%0d]", r), y_vec[r], want_y[r]);
            end
         end
      end else if (rst_n) begin
         // zero feed leaves nothing in the sums between vectors
         for (int r = 0; r < `MXU_ROWS; r++) begin
            check_acc($sformatf("y_vec[%0d]", r), y_vec[r], '0);
         end
      end
   end

   ////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////
   task automatic idle_cycles(int n);
      repeat (n) begin
         @(posedge clk);
         #2;
         start    = 1'b0;
         w_load   = 1'($urandom);  // ignored outside LOAD
         w_row    = random_vec(0);
         in_valid = 1'($urandom);  // ignored outside RUN
         in_last  = 1'($urandom);
         x_vec    = random_vec(0);
         @(negedge clk);
         check_flag("busy", busy, 1'b0);
         check_flag("loading", loading, 1'b0);
         check_flag("done", done, 1'b0);
         check_flag("out_valid", out_valid, 1'b0);
      end
   endtask

   task automatic load_weights(bit extreme);
      ovec_t row;
      for (int n = 0; n < `MXU_ROWS; n++) begin
         repeat ($urandom_range(2, 0)) begin
            @(posedge clk);
            #2;
            w_load   = 1'b0;
            in_valid = 1'($urandom);
            in_last  = 1'($urandom);
            x_vec    = random_vec(0);
            @(negedge clk);
            check_flag("loading", loading, 1'b1);
         end
         row = (extreme && n == 0) ? '1 : random_vec(extreme);
         @(posedge clk);
         #2;
         w_load   = 1'b1;
         w_row    = row;
         in_valid = 1'b0;
         for (int c = 0; c < `MXU_COLS; c++) begin
            w_model[`MXU_ROWS-1-n][c] = row[c];  // n-th row lands at the bottom
         end
         @(negedge clk);
         check_flag("loading", loading, 1'b1);
      end
      @(posedge clk);
      #2;
      w_row = random_vec(0);  // one strobe too many
      @(negedge clk);
      check_flag("loading", loading, 1'b1);
      @(posedge clk);
      #2;
      w_load = 1'b0;
      @(negedge clk);
      check_flag("loading", loading, 1'b0);
      check_flag("busy", busy, 1'b1);
   endtask

   task automatic stream_vectors(int nvec, int gap_max, bit extreme);
      ovec_t x;
      for (int v = 0; v < nvec; v++) begin
         repeat ($urandom_range(gap_max, 0)) begin
            @(posedge clk);
            #2;
            in_valid = 1'b0;
            in_last  = 1'($urandom);
            x_vec    = random_vec(0);  // must be fed as zeros
            w_load   = 1'($urandom);
            w_row    = random_vec(0);
         end
         x = (extreme && v == 0) ? '1 : random_vec(extreme);
         @(posedge clk);
         #2;
         in_valid = 1'b1;
         in_last  = (v == nvec - 1);
         x_vec    = x;
         w_load   = 1'($urandom);
         w_row    = random_vec(0);
         exp_y.push_back(expected_y(x));
         exp_cyc.push_back(cycle + PIPE_LAT);
         sent++;
      end
      last_cyc = cycle;
   endtask

   task automatic drain_and_finish();
      @(posedge clk);
      #2;
      in_valid  = 1'b1;  // late vector, start and precision all ignored
      in_last   = 1'b1;
      x_vec     = random_vec(0);
      start     = 1'b1;
      data_type = $urandom_range(1, 0) ? PREC_UINT8 : PREC_INT8;
      w_load    = 1'b0;
      @(posedge clk);
      #2;
      in_valid = 1'b0;
      in_last  = 1'b0;
      start    = 1'b0;
      @(negedge clk);
      while (done !== 1'b1) begin
         check_flag("busy", busy, 1'b1);
         @(negedge clk);
      end
      // drain timer needs one cycle past the last result to hit zero
      if (cycle != last_cyc + PIPE_LAT + 2) begin
         other_errs++;
         $display("Error at %t: done came in cycle %0d, expected in cycle %0d",
                  $realtime, cycle, last_cyc + PIPE_LAT + 2);
      end
      check_flag("busy", busy, 1'b0);
      if (exp_y.size() != 0) begin
         other_errs++;
         $display("Error at %t: %0d results still missing at done", $realtime, exp_y.size());
      end
      @(negedge clk);
      check_flag("done", done, 1'b0);
   endtask

   task automatic run_job(prec_e p, int nvec, int gap_max, bit extreme);
      cycle_limit = cycle + 8 + 3 * `MXU_ROWS + nvec * (gap_max + 1) + PIPE_LAT + 20;
      job_prec    = p;
      idle_cycles(3);
      @(posedge clk);
      #2;
      start     = 1'b1;
      data_type = p;
      w_load    = 1'b0;
      in_valid  = 1'b0;
      @(posedge clk);
      #2;
      start     = 1'b0;
      data_type = $urandom_range(1, 0) ? PREC_UINT8 : PREC_INT8;  // held inside
      @(negedge clk);
      check_flag("busy", busy, 1'b1);
      check_flag("loading", loading, 1'b1);
      load_weights(extreme);
      stream_vectors(nvec, gap_max, extreme);
      drain_and_finish();
   endtask

   initial begin
      start     = 1'b0;
      data_type = PREC_INT8;
      w_load    = 1'b0;
      w_row     = '0;
      in_valid  = 1'b0;
      in_last   = 1'b0;
      x_vec     = '0;
      $timeformat(-9, 1, " ns", 0);
      void'($urandom(32'h4675685c));

      @(posedge rst_n);
      idle_cycles(8);                   // quiet after reset
      run_job(PREC_INT8, 12, 0, 1'b0);  // back to back
      run_job(PREC_INT8, 16, 3, 1'b1);
      run_job(PREC_UINT8, 12, 0, 1'b1); // full acc width
      run_job(PREC_UINT8, 20, 4, 1'b0);
      run_job(PREC_INT8, 1, 0, 1'b0);
      idle_cycles(4);

      if (received != sent) begin
         other_errs++;
         $display("Error: %0d vectors sent but %0d results seen", sent, received);
      end
      $display("Summary: %0d vectors, %0d results, %0d value errors, %0d other errors",
               sent, received, value_errs, other_errs);
      if (value_errs == 0 && other_errs == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// ==== tests/tb_clkgen.sv ====
`timescale 1ns/100ps

module tb_clkgen #(
   parameter real PERIOD       = 20.0,
   parameter int  RESET_CYCLES = 16
) (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk   = 1'b0;
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #2 rst_n = 1'b1;  // released off the edge
   end

   always #(PERIOD / 2.0) clk = ~clk;

endmodule

// ==== logic/mxu_top.sv ====
`timescale 1ns/100ps
`include "mxu_macros.svh"

module mxu_top (
   input  logic                                   clk,
   input  logic                                   rst_n,
   input  logic                                   start,
   input  mxu_arith_pkg::prec_e                   data_type,
   input  logic                                   w_load,
   input  mxu_arith_pkg::operand_t [`MXU_COLS-1:0] w_row,
   input  logic                                   in_valid,
   input  logic                                   in_last,
   input  mxu_arith_pkg::operand_t [`MXU_COLS-1:0] x_vec,
   output mxu_arith_pkg::acc_t     [`MXU_ROWS-1:0] y_vec,
   output logic                                   out_valid,
   output logic                                   busy,
   output logic                                   loading,
   output logic                                   done
);
   import mxu_arith_pkg::*;
   import mxu_ctrl_pkg::*;

   logic                     expired;
   logic                     tmr_load;
   logic                     tmr_en;
   tmr_cnt_t                 tmr_value;
   prec_e                    prec;
   logic                     w_shift;
   logic                     feed_en;
   operand_t [`MXU_COLS-1:0] x_feed;   // zeros between vectors
   operand_t [`MXU_COLS-1:0] x_skew;
   acc_t     [`MXU_ROWS-1:0] row_sum;

   mxu_seq u_seq (
      .clk       (clk),
      .rst_n     (rst_n),
      .start     (start),
      .data_type (data_type),
      .w_load    (w_load),
      .in_valid  (in_valid),
      .in_last   (in_last),
      .expired   (expired),
      .tmr_load  (tmr_load),
      .tmr_value (tmr_value),
      .tmr_en    (tmr_en),
      .prec      (prec),
      .w_shift   (w_shift),
      .feed_en   (feed_en),
      .busy      (busy),
      .loading   (loading),
      .done      (done),
      .out_valid (out_valid)
   );

   mxu_timer u_timer (
      .clk        (clk),
      .rst_n      (rst_n),
      .load       (tmr_load),
      .load_value (tmr_value),
      .count_en   (tmr_en),
      .expired    (expired)
   );

   assign x_feed = feed_en ? x_vec : '0;

   ////////////////////////////////////////
   // wavefront alignment around the array
   ////////////////////////////////////////
   skew_line #(
      .payload_t (operand_t),
      .LANES     (`MXU_COLS),
      .DESKEW    (1'b0)
   ) u_in_skew (
      .clk      (clk),
      .rst_n    (rst_n),
      .lane_in  (x_feed),
      .lane_out (x_skew)
   );

   mxu_core u_core (
      .clk     (clk),
      .rst_n   (rst_n),
      .prec    (prec),
      .w_shift (w_shift),
      .w_row   (w_row),
      .data_in (x_skew),
      .row_sum (row_sum)
   );

   skew_line #(
      .payload_t (acc_t),
      .LANES     (`MXU_ROWS),
      .DESKEW    (1'b1)
   ) u_out_deskew (
      .clk      (clk),
      .rst_n    (rst_n),
      .lane_in  (row_sum),
      .lane_out (y_vec)
   );

endmodule

// ==== logic/mxu_seq.sv ====
`timescale 1ns/100ps
`include "mxu_macros.svh"

module mxu_seq (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   start,
   input  mxu_arith_pkg::prec_e   data_type,
   input  logic                   w_load,
   input  logic                   in_valid,
   input  logic                   in_last,
   input  logic                   expired,
   output logic                   tmr_load,
   output mxu_ctrl_pkg::tmr_cnt_t tmr_value,
   output logic                   tmr_en,
   output mxu_arith_pkg::prec_e   prec,
   output logic                   w_shift,
   output logic                   feed_en,
   output logic                   busy,
   output logic                   loading,
   output logic                   done,
   output logic                   out_valid
);
   import mxu_arith_pkg::*;
   import mxu_ctrl_pkg::*;

   seq_state_e          state_q;
   seq_state_e          state_d;
   logic [PIPE_LAT-1:0] valid_q;  // one bit per vector in flight

   ////////////////////////////////////////
   // strobe gating and timer control
   ////////////////////////////////////////
   assign w_shift  = (state_q == LOAD) && w_load && !expired;  // no extra row
   assign feed_en  = (state_q == RUN) && in_valid;
   assign tmr_load = ((state_q == IDLE) && start) || (feed_en && in_last);
   assign tmr_en   = w_shift || (state_q == DRAIN);

   // row count when idle, pipeline depth otherwise
   assign tmr_value = (state_q == IDLE) ? tmr_cnt_t'(`MXU_ROWS) : tmr_cnt_t'(PIPE_LAT);

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE:    if (start) state_d = LOAD;
         LOAD:    if (expired) state_d = RUN;
         RUN:     if (feed_en && in_last) state_d = DRAIN;
         DRAIN:   if (expired) state_d = IDLE;
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q <= IDLE;
         prec    <= PREC_INT8;
         done    <= 1'b0;
         valid_q <= '0;
      end else begin
         state_q <= state_d;
         if ((state_q == IDLE) && start) begin
            prec <= data_type;  // held for the whole job
         end
         done    <= (state_q == DRAIN) && expired;  // rises as busy falls
         valid_q <= (valid_q << 1) | PIPE_LAT'(feed_en);
      end
   end

   assign busy      = (state_q != IDLE);
   assign loading   = (state_q == LOAD);
   assign out_valid = valid_q[PIPE_LAT-1];

endmodule

// ==== logic/mxu_timer.sv ====
`timescale 1ns/100ps

module mxu_timer (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   load,
   input  mxu_ctrl_pkg::tmr_cnt_t load_value,
   input  logic                   count_en,
   output logic                   expired
);
   import mxu_ctrl_pkg::*;

   tmr_cnt_t count_q;

   // preset wins over counting, holds at zero
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         count_q <= '0;
      end else if (load) begin
         count_q <= load_value;
      end else if (count_en && !expired) begin
         count_q <= count_q - 1'b1;
      end
   end

   assign expired = (count_q == '0);

endmodule

// ==== logic/skew_line.sv ====
`timescale 1ns/100ps

module skew_line #(
   parameter type payload_t = logic [7:0],
   parameter int  LANES     = 4,
   parameter bit  DESKEW    = 1'b0  // 1 reverses the staircase
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  payload_t [LANES-1:0] lane_in,
   output payload_t [LANES-1:0] lane_out
);

   for (genvar n = 0; n < LANES; n++) begin : g_lane
      // skew delays lane n by n, deskew by LANES-1-n
      localparam int DEPTH = DESKEW ? (LANES - 1 - n) : n;

      if (DEPTH == 0) begin : g_thru
         assign lane_out[n] = lane_in[n];
      end else begin : g_dly
         payload_t stage_q [DEPTH];

         always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
               for (int i = 0; i < DEPTH; i++) begin
                  stage_q[i] <= '0;
               end
            end else begin
               stage_q[0] <= lane_in[n];
               for (int i = 1; i < DEPTH; i++) begin
                  stage_q[i] <= stage_q[i-1];
               end
            end
         end

         assign lane_out[n] = stage_q[DEPTH-1];
      end
   end

endmodule

// ==== logic/mxu_core.sv ====
`timescale 1ns/100ps
`include "mxu_macros.svh"

module mxu_core (
   input  logic                                   clk,
   input  logic                                   rst_n,
   input  mxu_arith_pkg::prec_e                   prec,
   input  logic                                   w_shift,
   input  mxu_arith_pkg::operand_t [`MXU_COLS-1:0] w_row,
   input  mxu_arith_pkg::operand_t [`MXU_COLS-1:0] data_in,
   output mxu_arith_pkg::acc_t     [`MXU_ROWS-1:0] row_sum
);
   import mxu_arith_pkg::*;

   // vertical links, index r is the input of row r
   operand_t data_v [`MXU_ROWS+1][`MXU_COLS];
   operand_t w_v    [`MXU_ROWS+1][`MXU_COLS];

   // horizontal partial sums, index c is the input of column c
   acc_t     psum_v [`MXU_ROWS][`MXU_COLS+1];

   ////////////////////////////////////////
   // top edge of the grid
   ////////////////////////////////////////
   for (genvar c = 0; c < `MXU_COLS; c++) begin : g_top
      assign data_v[0][c] = data_in[c];  // already skewed
      assign w_v[0][c]    = w_row[c];
   end

   ////////////////////////////////////////
   // cell grid
   ////////////////////////////////////////
   for (genvar r = 0; r < `MXU_ROWS; r++) begin : g_row
      assign psum_v[r][0] = '0;                  // row starts from zero
      assign row_sum[r]   = psum_v[r][`MXU_COLS];  // last column result

      for (genvar c = 0; c < `MXU_COLS; c++) begin : g_col
         mxu_mac u_mac (
            .clk      (clk),
            .rst_n    (rst_n),
            .prec     (prec),
            .w_shift  (w_shift),
            .w_in     (w_v[r][c]),
            .data_in  (data_v[r][c]),
            .psum_in  (psum_v[r][c]),
            .w_out    (w_v[r+1][c]),
            .data_out (data_v[r+1][c]),
            .psum_out (psum_v[r][c+1])
         );
      end
   end

endmodule

// ==== logic/mxu_mac.sv ====
`timescale 1ns/100ps
`include "mxu_macros.svh"

module mxu_mac (
   input  logic                    clk,
   input  logic                    rst_n,
   input  mxu_arith_pkg::prec_e    prec,
   input  logic                    w_shift,
   input  mxu_arith_pkg::operand_t w_in,
   input  mxu_arith_pkg::operand_t data_in,
   input  mxu_arith_pkg::acc_t     psum_in,
   output mxu_arith_pkg::operand_t w_out,
   output mxu_arith_pkg::operand_t data_out,
   output mxu_arith_pkg::acc_t     psum_out
);
   import mxu_arith_pkg::*;

   operand_t                    weight_q;  // stationary weight
   logic signed [`MXU_DATA_W:0] w_ext;
   logic signed [`MXU_DATA_W:0] d_ext;
   acc_t                        product;

   // one extra top bit picks signed or unsigned
   always_comb begin
      w_ext   = {(prec == PREC_INT8) & weight_q[`MXU_DATA_W-1], weight_q};
      d_ext   = {(prec == PREC_INT8) & data_in[`MXU_DATA_W-1], data_in};
      product = w_ext * d_ext;  // widened to acc_t
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         weight_q <= '0;
         data_out <= '0;
         psum_out <= '0;
      end else begin
         if (w_shift) begin
            weight_q <= w_in;
         end
         data_out <= data_in;            // to the row below
         psum_out <= psum_in + product;  // to the next column
      end
   end

   assign w_out = weight_q;  // weight chain for loading

endmodule

// ==== logic/mxu_ctrl_pkg.sv ====
`include "mxu_macros.svh"

package mxu_ctrl_pkg;

   // sequencer phases
   typedef enum logic [1:0] {
      IDLE  = 2'd0,
      LOAD  = 2'd1,
      RUN   = 2'd2,
      DRAIN = 2'd3
   } seq_state_e;

   // edge of in_valid to edge of out_valid
   localparam int PIPE_LAT = `MXU_ROWS + `MXU_COLS - 1;

   // timer must hold MXU_ROWS and PIPE_LAT
   localparam int TMR_W = $clog2(PIPE_LAT + 1);
   typedef logic [TMR_W-1:0] tmr_cnt_t;

endpackage

// ==== logic/mxu_arith_pkg.sv ====
`include "mxu_macros.svh"

package mxu_arith_pkg;

   ////////////////////////////////////////
   // element types
   ////////////////////////////////////////

   // raw operand bits, interpretation set by prec_e
   typedef logic [`MXU_DATA_W-1:0] operand_t;

   // two's complement accumulation
   typedef logic signed [`MXU_ACC_W-1:0] acc_t;

   // operand extension before the multiply
   typedef enum logic {
      PREC_INT8  = 1'b0,  // sign extend
      PREC_UINT8 = 1'b1   // zero extend
   } prec_e;

endpackage

// ==== logic/mxu_macros.svh ====
`ifndef MXU_MACROS_SVH
`define MXU_MACROS_SVH

////////////////////////////////////////
// array shape
////////////////////////////////////////
`define MXU_ROWS 4   // weight rows, one result per row
`define MXU_COLS 4   // elements per input vector

// operand and accumulator widths
`define MXU_DATA_W 8
`define MXU_ACC_W  20  // 16 product bits plus column sum guard

`endif
